/* design/arya_pkg.sv */
`default_nettype none

package arya_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    // datapath and memory word
    localparam int data_w      = 64;
    // full memory, instruction half plus data half
    localparam int mem_addr_w  = 10;
    localparam int inst_addr_w = 9;
    localparam int reg_addr_w  = 5;
    // immediate field, sign-extended to data_w
    localparam int imm_w       = 13;

    localparam int mem_words   = 2 ** mem_addr_w;
    localparam int reg_count   = 2 ** reg_addr_w;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef logic [data_w-1:0]      word_t;
    typedef logic [mem_addr_w-1:0]  mem_addr_t;
    // also the index into the data half
    typedef logic [inst_addr_w-1:0] inst_addr_t;
    typedef logic [reg_addr_w-1:0]  reg_addr_t;
    // low 32 bits of a memory word
    typedef logic [31:0]            instr_t;

    // unlisted codes run as nop
    typedef enum logic [3:0] {
        op_nop   = 4'd0,
        op_add   = 4'd1,
        op_sub   = 4'd2,
        op_and   = 4'd3,
        op_or    = 4'd4,
        op_xor   = 4'd5,
        op_addi  = 4'd6,
        op_load  = 4'd7,
        op_store = 4'd8,
        op_halt  = 4'd15
    } opcode_e;

    // one instruction at a time through the five phases
    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback,
        st_halted
    } seq_state_e;

endpackage

`default_nettype wire

/* design/arya_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module arya_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    input  logic is_halt,
    output logic fetch_en,
    output logic decode_en,
    output logic execute_en,
    output logic memory_en,
    output logic writeback_en,
    output logic halted
);
    import arya_pkg::*;

    seq_state_e state;
    seq_state_e state_nxt;

    // state register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                // wait for run request
                if (en) begin
                    state_nxt = st_fetch;
                end
            end
            st_fetch:     state_nxt = st_decode;
            st_decode:    state_nxt = st_execute;
            st_execute: begin
                // halt stops after execute, no memory or writeback
                if (is_halt) begin
                    state_nxt = st_halted;
                end else begin
                    state_nxt = st_memory;
                end
            end
            st_memory:    state_nxt = st_writeback;
            st_writeback: state_nxt = st_fetch;
            // stuck here until reset
            st_halted:    state_nxt = st_halted;
            default:      state_nxt = st_idle;
        endcase
    end

    // one strobe per phase
    assign fetch_en     = (state == st_fetch);
    assign decode_en    = (state == st_decode);
    assign execute_en   = (state == st_execute);
    assign memory_en    = (state == st_memory);
    assign writeback_en = (state == st_writeback);
    assign halted       = (state == st_halted);

endmodule

`default_nettype wire

/* design/arya_pc.sv */
`timescale 1ns/10ps
`default_nettype none

module arya_pc (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pc_step,
    output arya_pkg::inst_addr_t pc
);
    import arya_pkg::*;

    inst_addr_t pc_q;

    //////////////////////////////////////////////////////////////////////
    // instruction pointer
    //////////////////////////////////////////////////////////////////////

    // start of program after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (pc_step) begin
            // natural wrap at 512, stays in lower half
            pc_q <= pc_q + 1'b1;
        end
    end

    // no branches, so only ever steps
    assign pc = pc_q;

endmodule

`default_nettype wire

/* design/arya_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module arya_mem (
    input  logic                 clk,
    input  logic                 setup_mem,
    input  logic                 verify_mem,
    input  arya_pkg::mem_addr_t  mem_addr_in,
    input  arya_pkg::word_t      mem_data_in,
    input  arya_pkg::inst_addr_t pc,
    input  arya_pkg::inst_addr_t data_index,
    input  logic                 data_phase,
    input  logic                 store_en,
    input  arya_pkg::word_t      store_data,
    output arya_pkg::word_t      rdata
);
    import arya_pkg::*;

    word_t     mem [mem_words];
    mem_addr_t addr;
    logic      ext_access;
    logic      we;
    word_t     wdata;

    // outside port owns the memory while high
    assign ext_access = setup_mem || verify_mem;

    // address select
    always_comb begin
        if (ext_access) begin
            addr = mem_addr_in;
        end else if (data_phase) begin
            // data half at 512 + index
            addr = {1'b1, data_index};
        end else begin
            // instructions in lower half
            addr = {1'b0, pc};
        end
    end

    // core store blocked during outside access
    assign we    = setup_mem || (store_en && !ext_access);
    assign wdata = setup_mem ? mem_data_in : store_data;

    // sync write, registered read with old data on collision
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* design/arya_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module arya_decoder (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                decode_en,
    input  arya_pkg::word_t     rdata,
    output arya_pkg::reg_addr_t ra,
    output arya_pkg::reg_addr_t rb,
    output arya_pkg::reg_addr_t rd,
    output arya_pkg::word_t     imm,
    output arya_pkg::opcode_e   opcode,
    output logic                is_halt,
    output logic                mem_to_reg,
    output logic                writes_reg,
    output logic                is_store
);
    import arya_pkg::*;

    instr_t ir;

    // instruction register, nop out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (decode_en) begin
            // instruction sits in low half of the word
            ir <= rdata[31:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // fields
    //////////////////////////////////////////////////////////////////////

    assign opcode = opcode_e'(ir[31:28]);
    assign ra     = ir[27:23];
    assign rb     = ir[22:18];
    assign rd     = ir[17:13];
    // sign extend imm
    assign imm    = {{(data_w - imm_w){ir[imm_w-1]}}, ir[imm_w-1:0]};

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        writes_reg = 1'b0;
        mem_to_reg = 1'b0;
        is_store   = 1'b0;
        case (opcode)
            op_add, op_sub, op_and, op_or, op_xor, op_addi: begin
                writes_reg = 1'b1;
            end
            op_load: begin
                // rd gets the word read in memory phase
                writes_reg = 1'b1;
                mem_to_reg = 1'b1;
            end
            op_store: is_store = 1'b1;
            // nop, halt and unused codes do nothing here
            default: writes_reg = 1'b0;
        endcase
    end

    assign is_halt = (opcode == op_halt);

endmodule

`default_nettype wire

/* design/arya_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module arya_regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  arya_pkg::reg_addr_t ra,
    input  arya_pkg::reg_addr_t rb,
    input  arya_pkg::reg_addr_t rd,
    input  logic                reg_we,
    input  arya_pkg::word_t     wdata,
    output arya_pkg::word_t     ra_data,
    output arya_pkg::word_t     rb_data
);
    import arya_pkg::*;

    word_t regs [reg_count];

    // single write port, all registers cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_we) begin
            // r0 is an ordinary register
            regs[rd] <= wdata;
        end
    end

    // two async read ports
    assign ra_data = regs[ra];
    assign rb_data = regs[rb];

endmodule

`default_nettype wire

/* design/arya_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module arya_alu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              execute_en,
    input  arya_pkg::opcode_e opcode,
    input  arya_pkg::word_t   a,
    input  arya_pkg::word_t   b,
    input  arya_pkg::word_t   imm,
    output arya_pkg::word_t   result
);
    import arya_pkg::*;

    word_t alu_out;

    // operation select
    always_comb begin
        case (opcode)
            op_add:   alu_out = a + b;
            op_sub:   alu_out = a - b;
            op_and:   alu_out = a & b;
            op_or:    alu_out = a | b;
            op_xor:   alu_out = a ^ b;
            // address or immediate sum
            op_addi, op_load, op_store: alu_out = a + imm;
            default:  alu_out = '0;
        endcase
    end

    // result held through memory and writeback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (execute_en) begin
            result <= alu_out;
        end
    end

endmodule

`default_nettype wire

/* design/arya.sv */
`timescale 1ns/10ps
`default_nettype none

module arya (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en,
    input  logic                setup_mem,
    input  logic                verify_mem,
    input  arya_pkg::mem_addr_t mem_addr_in,
    input  arya_pkg::word_t     mem_data_in,
    output arya_pkg::word_t     mem_data_out,
    output logic                halted
);
    import arya_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // wires
    //////////////////////////////////////////////////////////////////////

    // phase strobes
    logic       decode_en;
    logic       execute_en;
    logic       memory_en;
    logic       writeback_en;
    // decode outputs
    reg_addr_t  ra;
    reg_addr_t  rb;
    reg_addr_t  rd;
    word_t      imm;
    opcode_e    opcode;
    logic       is_halt;
    logic       mem_to_reg;
    logic       writes_reg;
    logic       is_store;
    // datapath
    inst_addr_t pc;
    word_t      ra_data;
    word_t      rb_data;
    word_t      alu_result;

    //////////////////////////////////////////////////////////////////////
    // instances
    //////////////////////////////////////////////////////////////////////

    // memory follows the pc outside memory phase, so fetch strobe stays open
    arya_sequencer i_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .is_halt      (is_halt),
        .fetch_en     (),
        .decode_en    (decode_en),
        .execute_en   (execute_en),
        .memory_en    (memory_en),
        .writeback_en (writeback_en),
        .halted       (halted)
    );

    // pc advances once per finished instruction
    arya_pc i_pc (
        .clk     (clk),
        .rst_n   (rst_n),
        .pc_step (writeback_en),
        .pc      (pc)
    );

    // pc addresses the memory in every phase except memory
    arya_mem i_mem (
        .clk         (clk),
        .setup_mem   (setup_mem),
        .verify_mem  (verify_mem),
        .mem_addr_in (mem_addr_in),
        .mem_data_in (mem_data_in),
        .pc          (pc),
        .data_index  (alu_result[inst_addr_w-1:0]),
        .data_phase  (memory_en),
        .store_en    (memory_en && is_store),
        .store_data  (rb_data),
        .rdata       (mem_data_out)
    );

    arya_decoder i_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .decode_en  (decode_en),
        .rdata      (mem_data_out),
        .ra         (ra),
        .rb         (rb),
        .rd         (rd),
        .imm        (imm),
        .opcode     (opcode),
        .is_halt    (is_halt),
        .mem_to_reg (mem_to_reg),
        .writes_reg (writes_reg),
        .is_store   (is_store)
    );

    // load data arrives from memory in writeback
    arya_regfile i_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .ra      (ra),
        .rb      (rb),
        .rd      (rd),
        .reg_we  (writeback_en && writes_reg),
        .wdata   (mem_to_reg ? mem_data_out : alu_result),
        .ra_data (ra_data),
        .rb_data (rb_data)
    );

    arya_alu i_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .execute_en (execute_en),
        .opcode     (opcode),
        .a          (ra_data),
        .b          (rb_data),
        .imm        (imm),
        .result     (alu_result)
    );

endmodule

`default_nettype wire

/* tests/arya_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module arya_assert (
    input logic clk,
    input logic rst_n,
    input logic setup_mem,
    input logic verify_mem,
    input logic halted,
    input logic mem_we
);
    // failure counts, one per property
    int dual_fails  = 0;
    int hold_fails  = 0;
    int store_fails = 0;

    // outside port is a write or a read, never both
    no_dual_access: assert property (@(posedge clk) disable iff (!rst_n)
        !(setup_mem && verify_mem))
        else begin
            $error("setup_mem and verify_mem high in the same cycle");
            dual_fails++;
        end

    // halted is sticky until reset
    halt_holds: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else begin
            $error("halted dropped while rst_n was high");
            hold_fails++;
        end

    // memory write enable seen at the array, only outside setup may write once stopped
    no_store_halted: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !(mem_we && !setup_mem))
        else begin
            $error("core memory write while halted");
            store_fails++;
        end

endmodule

bind arya arya_assert i_arya_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .setup_mem  (setup_mem),
    .verify_mem (verify_mem),
    .halted     (halted),
    .mem_we     (i_mem.we)
);

`default_nettype wire

/* tests/arya_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module arya_tb;
    import arya_pkg::*;

    localparam int clk_period = 100;
    localparam int n_setup    = 48;
    localparam int alu_ops    = 40;
    localparam int ls_iters   = 16;
    localparam int max_prog   = 100;
    localparam int n_runs     = 4;
    // data half fill and readback plus the longest program
    localparam int run_cycles   = 3 * 512 + 6 * max_prog + 20;
    localparam int limit_cycles = 2 * (3 * n_setup + n_runs * run_cycles);

    logic      clk         = 1'b0;
    logic      rst_n       = 1'b0;
    logic      en          = 1'b0;
    logic      setup_mem   = 1'b0;
    logic      verify_mem  = 1'b0;
    mem_addr_t mem_addr_in = '0;
    word_t     mem_data_in = '0;
    word_t     mem_data_out;
    logic      halted;

    int        seed = 84;
    // reference model state
    word_t     model_regs [reg_count];
    word_t     model_mem  [mem_words];
    word_t     prog [$];
    mem_addr_t setup_addrs [$];

    arya i_arya (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .setup_mem    (setup_mem),
        .verify_mem   (verify_mem),
        .mem_addr_in  (mem_addr_in),
        .mem_data_in  (mem_data_in),
        .mem_data_out (mem_data_out),
        .halted       (halted)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_on_error();
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    // watchdog
    initial begin
        #(limit_cycles * clk_period);
        $display("timeout after %0d cycles, DUT did not finish", limit_cycles);
        stop_on_error();
    end

    task automatic check(input string name, input word_t exp, input word_t got);
        assert (got === exp) else begin
            $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    // background data for the data half, differs per address
    function automatic word_t fill_word(input mem_addr_t a);
        logic [31:0] x;
        x = {22'd0, a};
        return {32'hfeed0000 | x, x * 32'h9e3779b1};
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        en    <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("halted", 64'd0, {63'd0, halted});
    endtask

    //////////////////////////////////////////////////////////////////////
    // outside memory port
    //////////////////////////////////////////////////////////////////////

    task automatic write_word(input mem_addr_t a, input word_t d);
        @(posedge clk);
        setup_mem   <= 1'b1;
        mem_addr_in <= a;
        mem_data_in <= d;
    endtask

    task automatic release_bus();
        @(posedge clk);
        setup_mem  <= 1'b0;
        verify_mem <= 1'b0;
    endtask

    // word shows on mem_data_out one cycle after the request
    task automatic read_check(input mem_addr_t a);
        @(posedge clk);
        verify_mem  <= 1'b1;
        mem_addr_in <= a;
        @(posedge clk);
        verify_mem <= 1'b0;
        @(negedge clk);
        check($sformatf("mem_data_out[%0d]", a), model_mem[a], mem_data_out);
    endtask

    task automatic verify_data_half();
        for (int i = 0; i < 512; i++) begin
            read_check({1'b1, i[8:0]});
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // program generation and reference model
    //////////////////////////////////////////////////////////////////////

    // append one instruction and execute it on the model
    task automatic emit(input logic [3:0] op, input reg_addr_t ra, input reg_addr_t rb,
                        input reg_addr_t rd, input logic [12:0] imm);
        word_t      a;
        word_t      b;
        word_t      simm;
        word_t      sum;
        logic [8:0] idx;
        prog.push_back({32'h0, op, ra, rb, rd, imm});
        a    = model_regs[ra];
        b    = model_regs[rb];
        simm = {{51{imm[12]}}, imm};
        sum  = a + simm;
        // data index wraps inside the upper half
        idx  = sum[8:0];
        case (op)
            op_add:   model_regs[rd] = a + b;
            op_sub:   model_regs[rd] = a - b;
            op_and:   model_regs[rd] = a & b;
            op_or:    model_regs[rd] = a | b;
            op_xor:   model_regs[rd] = a ^ b;
            op_addi:  model_regs[rd] = sum;
            op_load:  model_regs[rd] = model_mem[{1'b1, idx}];
            op_store: model_mem[{1'b1, idx}] = b;
            default:  ;
        endcase
    endtask

    task automatic new_program();
        prog.delete();
        for (int i = 0; i < reg_count; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 512; i++) begin
            model_mem[{1'b1, i[8:0]}] = fill_word({1'b1, i[8:0]});
        end
    endtask

    // random reg ops, then r0..r31 stored to indices 0..31
    task automatic gen_alu_program();
        logic [31:0] r;
        logic [31:0] s;
        logic [8:0]  ofs;
        for (int i = 0; i < alu_ops; i++) begin
            r = $random(seed);
            s = $random(seed);
            if (r[2:0] > 3'd4) begin
                emit(op_addi, r[15:11], r[20:16], r[25:21], s[12:0]);
            end else begin
                emit({1'b0, r[2:0]} + 4'd1, r[15:11], r[20:16], r[25:21], s[12:0]);
            end
        end
        for (int i = 0; i < reg_count; i++) begin
            // offset cancels the current r0 so the index is i
            ofs = i[8:0] - model_regs[0][8:0];
            emit(op_store, 5'd0, i[4:0], 5'd0, {4'd0, ofs});
        end
        emit(op_halt, 5'd0, 5'd0, 5'd0, 13'd0);
    endtask

    task automatic gen_load_store_program();
        logic [31:0] r;
        logic [31:0] s;
        reg_addr_t   rx;
        for (int k = 0; k < ls_iters; k++) begin
            r  = $random(seed);
            s  = $random(seed);
            rx = r[4:0];
            emit(op_addi, r[9:5], 5'd0, rx, s[12:0]);
            emit(op_store, r[14:10], rx, 5'd0, s[25:13]);
            // load back into the neighbour register, then store it elsewhere
            emit(op_load, r[14:10], 5'd0, rx ^ 5'd1, s[25:13]);
            emit(op_store, r[19:15], rx ^ 5'd1, 5'd0, {s[31:26], r[26:20]});
        end
        emit(op_halt, 5'd0, 5'd0, 5'd0, 13'd0);
    endtask

    // nop and unused opcodes only
    task automatic gen_nop_program();
        logic [31:0] r;
        logic [3:0]  op;
        int          n;
        r = $random(seed);
        n = 4 + int'(r[2:0]);
        for (int i = 0; i < n; i++) begin
            r  = $random(seed);
            op = r[31:28];
            if (op < 4'd9 || op == 4'd15) begin
                op = 4'd0;
            end
            emit(op, r[27:23], r[22:18], r[17:13], r[12:0]);
        end
        emit(op_halt, 5'd0, 5'd0, 5'd0, 13'd0);
    endtask

    task automatic load_memory();
        for (int i = 0; i < 512; i++) begin
            write_word({1'b1, i[8:0]}, fill_word({1'b1, i[8:0]}));
        end
        for (int i = 0; i < prog.size(); i++) begin
            model_mem[{1'b0, i[8:0]}] = prog[i];
            write_word({1'b0, i[8:0]}, prog[i]);
        end
        release_bus();
    endtask

    // halted must rise 5 cycles per instruction plus 4 after en
    task automatic run_program(input int n_instr);
        int cycles;
        @(posedge clk);
        en <= 1'b1;
        @(negedge clk);
        cycles = 0;
        while (halted !== 1'b1) begin
            @(negedge clk);
            cycles++;
        end
        check("halted delay", 64'(5 * n_instr + 4), 64'(cycles));
        @(posedge clk);
        en <= 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [31:0] s;
        int          n_alu;
        apply_reset();

        // outside write then readback, core stays idle
        for (int i = 0; i < n_setup; i++) begin
            r = $random(seed);
            s = $random(seed);
            setup_addrs.push_back(r[9:0]);
            model_mem[r[9:0]] = {r, s};
            write_word(r[9:0], {r, s});
        end
        release_bus();
        foreach (setup_addrs[i]) begin
            read_check(setup_addrs[i]);
        end

        // register ops program
        new_program();
        gen_alu_program();
        n_alu = prog.size() - 1;
        load_memory();
        run_program(n_alu);
        verify_data_half();

        // same image again after reset, memory not reloaded
        apply_reset();
        run_program(n_alu);
        verify_data_half();

        apply_reset();
        new_program();
        gen_load_store_program();
        load_memory();
        run_program(prog.size() - 1);
        verify_data_half();

        // whole data half keeps its fill
        apply_reset();
        new_program();
        gen_nop_program();
        load_memory();
        run_program(prog.size() - 1);
        verify_data_half();

        if (i_arya.i_arya_assert.dual_fails + i_arya.i_arya_assert.hold_fails
                + i_arya.i_arya_assert.store_fails == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("bound assertions on the DUT reported failures");
            stop_on_error();
        end
    end

endmodule

`default_nettype wire

/* files.f */
design/arya_pkg.sv
design/arya_sequencer.sv
design/arya_pc.sv
design/arya_mem.sv
design/arya_decoder.sv
design/arya_regfile.sv
design/arya_alu.sv
design/arya.sv
tests/arya_assert.sv
tests/arya_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module arya_tb \
    -f files.f -Mdir obj_dir -o arya_sim > build.log 2>&1 \
    && ./obj_dir/arya_sim > sim.log 2>&1 ; \
grep -qxF '>>> PASS' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
